// File: all.f
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_sva.sv
tb_uart_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_uart_top -f all.f \
   && ./obj_dir/Vtb_uart_top | grep -x "Regression passed" \
   && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }

// File: tb_uart_sva.sv
module uart_sva
#(
   parameter int P_NIB_CNT_W = 2
)
(
   input logic                   clk,
   input logic                   rst,
   input logic                   i_fifo_full,
   input logic [2:0]             i_fmt_state,
   input logic [P_NIB_CNT_W-1:0] i_nib_cnt,
   input logic                   i_tx_active,
   input logic                   i_tx,
   input logic                   i_rx_valid,
   input logic                   i_tx_busy
);

   // Formatter must stall on back-pressure, every write moves state or nibble count
   a_no_write_full: assert property (@(posedge clk) disable iff (rst)
      i_tx_busy && i_fifo_full |=> $stable(i_fmt_state) && $stable(i_nib_cnt))
      else $error("Formatter moved on while FIFO full");

   a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
      !i_tx_active |-> i_tx)
      else $error("Serial line low while transmitter idle");

   a_rx_valid_single: assert property (@(posedge clk) disable iff (rst)
      i_rx_valid |=> !i_rx_valid)
      else $error("Receive strobe held for two cycles");

   a_busy_after_reset: assert property (@(posedge clk)
      rst |=> !i_tx_busy)
      else $error("Busy flag set right after reset");

endmodule

bind uart_top uart_sva #(
   .P_NIB_CNT_W (LP_NCW)
) u_sva (
   .clk         (clk),
   .rst         (rst),
   .i_fifo_full (fifo_full),
   .i_fmt_state (state),
   .i_nib_cnt   (nib_cnt),
   .i_tx_active (tx_active),
   .i_tx        (o_tx),
   .i_rx_valid  (o_rx_valid),
   .i_tx_busy   (o_tx_busy)
);

// File: tb_uart_top.sv
module tb_uart_top
   import uart_pkg::*;
();

   localparam int LP_CLKS   = 16;
   localparam int LP_PERIOD = 20;
   localparam int LP_WIDTH  = 16;

   typedef struct packed {
      byte_t       kind; // T report, B strobe while busy, R receive byte
      logic [31:0] f1;
      logic [31:0] f2;
   } pattern_t;

   logic                clk;
   logic                rst;
   logic                i_rx;
   reg_sel_t            i_tx_reg;
   logic [LP_WIDTH-1:0] i_tx_data;
   logic                i_tx_stb;
   logic                o_tx;
   logic                o_tx_busy;
   byte_t               o_rx_data;
   logic                o_rx_valid;

   pattern_t    pats[$];
   byte_t       exp_tx[$]; // Characters still due on o_tx
   byte_t       exp_rx[$];
   int          tx_errors;
   int          rx_errors;
   int          other_errors;
   bit          loaded;
   bit          reset_done;
   logic [15:0] hex_seen;
   logic [3:0]  reg_seen;

   uart_top #(
      .P_DP_WIDTH     (LP_WIDTH),
      .P_CLKS_PER_BIT (LP_CLKS),
      .P_FIFO_DEPTH   (8)
   ) UUT (
      .clk        (clk),
      .rst        (rst),
      .i_rx       (i_rx),
      .i_tx_reg   (i_tx_reg),
      .i_tx_data  (i_tx_data),
      .i_tx_stb   (i_tx_stb),
      .o_tx       (o_tx),
      .o_tx_busy  (o_tx_busy),
      .o_rx_data  (o_rx_data),
      .o_rx_valid (o_rx_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(LP_PERIOD / 2) clk = ~clk;
   end

   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic load_patterns(output bit ok);
      int          fd;
      int          n;
      string       line;
      byte_t       kc;
      logic [31:0] a;
      logic [31:0] b;
      ok = 1'b0;
      fd = $fopen("uart_patterns.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%c %h %h", kc, a, b);
               if (n == 3)
                  pats.push_back('{kind: kc, f1: a, f2: b});
            end
         end
         $fclose(fd);
         ok = 1'b1;
      end
   endtask

   // Expected line built from the report format
   task automatic queue_report(input reg_sel_t r, input logic [LP_WIDTH-1:0] d);
      string      hex_digits;
      string      reg_digits;
      logic [3:0] nib;
      hex_digits = "0123456789ABCDEF";
      reg_digits = "0123";
      exp_tx.push_back(CH_R);
      exp_tx.push_back(reg_digits[r]);
      exp_tx.push_back(CH_COLON);
      for (int i = LP_WIDTH / 4 - 1; i >= 0; i--)
      begin
         nib = d[i*4 +: 4]; // Most significant nibble first
         exp_tx.push_back(hex_digits[nib]);
         hex_seen[nib] = 1'b1;
      end
      exp_tx.push_back(CH_NL);
      exp_tx.push_back(CH_CR);
      reg_seen[r] = 1'b1;
   endtask

   task automatic send_strobe(input reg_sel_t r, input logic [LP_WIDTH-1:0] d,
                              input bit accepted);
      i_tx_reg  = r;
      i_tx_data = d;
      i_tx_stb  = 1'b1;
      if (accepted)
         queue_report(r, d);
      tick();
      i_tx_stb = 1'b0;
      if (accepted && !o_tx_busy)
      begin
         $display("o_tx_busy did not rise after an accepted request at %0t", $time);
         other_errors++;
      end
   endtask

   task automatic send_serial(input byte_t b, input logic stop);
      if (stop)
         exp_rx.push_back(b);
      i_rx = 1'b0;
      repeat (LP_CLKS) tick();
      for (int i = 0; i < 8; i++)
      begin
         i_rx = b[i];
         repeat (LP_CLKS) tick();
      end
      i_rx = stop;
      repeat (LP_CLKS) tick();
      i_rx = 1'b1;
      repeat (2 * LP_CLKS) tick(); // Idle gap
   endtask

   task automatic run_pattern(input pattern_t p);
      case (p.kind)
         "T":
         begin
            while (o_tx_busy)
               tick();
            send_strobe(p.f1[1:0], p.f2[LP_WIDTH-1:0], 1'b1);
         end
         "B":
         begin
            // Port must still be busy with the previous report
            if (!o_tx_busy)
            begin
               $display("Port idle when a strobe for the busy case was issued at %0t",
                        $time);
               other_errors++;
            end
            send_strobe(p.f1[1:0], p.f2[LP_WIDTH-1:0], 1'b0);
         end
         "R":
            send_serial(p.f1[7:0], p.f2[0]);
         default:
         begin
            $display("Unknown pattern kind %c in uart_patterns.txt", p.kind);
            other_errors++;
         end
      endcase
   endtask

   // Serial decoder on o_tx, samples near mid-bit
   initial
   begin
      byte_t c;
      byte_t e;
      wait (reset_done);
      forever
      begin
         @(negedge o_tx);
         repeat (LP_CLKS / 2) @(negedge clk);
         if (o_tx !== 1'b0)
         begin
            $display("Start bit on o_tx too short at %0t", $time);
            other_errors++;
         end
         else
         begin
            for (int i = 0; i < 8; i++)
            begin
               repeat (LP_CLKS) @(negedge clk);
               c[i] = o_tx;
            end
            repeat (LP_CLKS) @(negedge clk);
            if (o_tx !== 1'b1)
            begin
               $display("Stop bit low on o_tx at %0t", $time);
               other_errors++;
            end
            if (exp_tx.size() == 0)
            begin
               $display("Unexpected character %02h on o_tx at %0t", c, $time);
               other_errors++;
            end
            else
            begin
               e = exp_tx.pop_front();
               if (c !== e)
               begin
                  $display("Mismatch at %0t: o_tx char %02h, expected %02h", $time, c, e);
                  tx_errors++;
               end
            end
         end
      end
   end

   always @(negedge clk)
   begin
      byte_t e;
      if (reset_done && o_rx_valid === 1'b1)
      begin
         if (exp_rx.size() == 0)
         begin
            $display("Unexpected o_rx_valid pulse at %0t", $time);
            other_errors++;
         end
         else
         begin
            e = exp_rx.pop_front();
            if (o_rx_data !== e)
            begin
               $display("Mismatch at %0t: o_rx_data %02h, expected %02h", $time, o_rx_data, e);
               rx_errors++;
            end
         end
      end
   end

   initial
   begin
      longint limit;
      wait (loaded);
      limit = longint'(pats.size()) * 12 * 10 * LP_CLKS * LP_PERIOD + 200_000;
      #(limit);
      $display("Timeout after %0d time units, traffic did not complete", limit);
      $display("Regression failed");
      $finish;
   end

   initial
   begin
      bit ok;
      rst          = 1'b1;
      i_rx         = 1'b1;
      i_tx_reg     = '0;
      i_tx_data    = '0;
      i_tx_stb     = 1'b0;
      tx_errors    = 0;
      rx_errors    = 0;
      other_errors = 0;
      hex_seen     = '0;
      reg_seen     = '0;
      reset_done   = 1'b0;
      loaded       = 1'b0;
      load_patterns(ok);
      if (!ok)
      begin
         $display("Cannot open uart_patterns.txt");
         $display("Regression failed");
         $finish;
      end
      else
      begin
         loaded = 1'b1;
         repeat (4) @(posedge clk);
         #2;
         rst        = 1'b0;
         reset_done = 1'b1;
         foreach (pats[k])
            run_pattern(pats[k]);
         while (exp_tx.size() != 0)
            tick();
         repeat (20 * LP_CLKS) tick(); // Room for a stray extra line
         if (exp_rx.size() != 0)
         begin
            $display("No o_rx_valid pulse for %0d received bytes", exp_rx.size());
            other_errors++;
         end
         if (hex_seen != 16'hffff || reg_seen != 4'hf)
         begin
            $display("Reports do not cover every hex digit and register number");
            other_errors++;
         end
         $display("Error counts: tx %0d, rx %0d, other %0d",
                  tx_errors, rx_errors, other_errors);
         if (tx_errors + rx_errors + other_errors == 0)
            $display("Regression passed");
         else
            $display("Regression failed");
         $finish;
      end
   end

endmodule

// File: uart_fifo.sv
module uart_fifo
   import uart_pkg::*;
#(
   parameter int P_FIFO_DEPTH = 8
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  i_wr,
   input  byte_t i_din,
   input  logic  i_rd,
   output byte_t o_dout,
   output logic  o_full,
   output logic  o_empty
);

   localparam int LP_AW = $clog2(P_FIFO_DEPTH);

   byte_t          mem [P_FIFO_DEPTH];
   logic [LP_AW:0] wr_ptr; // Extra MSB tells full from empty
   logic [LP_AW:0] rd_ptr;
   logic           do_wr;
   logic           do_rd;

   assign do_wr = i_wr && !o_full;
   assign do_rd = i_rd && !o_empty;

   // Pointers wrap naturally at the buffer size
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Storage only, no reset
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr[LP_AW-1:0]] <= i_din;
   end

   assign o_dout  = mem[rd_ptr[LP_AW-1:0]]; // Head entry, no read latency
   assign o_empty = (wr_ptr == rd_ptr);
   assign o_full  = (wr_ptr[LP_AW] != rd_ptr[LP_AW]) &&
                    (wr_ptr[LP_AW-1:0] == rd_ptr[LP_AW-1:0]);

endmodule

// File: uart_patterns.txt
# T reg data : report request once idle, B reg data : strobe while busy (ignored)
# R byte stop : serial byte on i_rx with its stop bit level
T 2 0A5F
T 0 1234
T 1 6789
B 3 FFFF
T 3 BCDE
T 2 0000
B 1 1111
R 55 1
R A3 1
R 00 1
R 7E 0
R C9 1
T 1 F0E1
R FF 1
R 3C 0
R 81 1
T 0 ABCD

// File: uart_pkg.sv
package uart_pkg;

   // One character on the line or in the FIFO
   typedef logic [7:0] byte_t;

   // Register number carried by a report request
   typedef logic [1:0] reg_sel_t;

   // Received byte with its one-cycle strobe
   typedef struct packed {
      byte_t data;
      logic  valid;
   } rx_word_t;

   // Fixed characters of a report line
   localparam byte_t CH_R     = 8'h52; // "R"
   localparam byte_t CH_COLON = 8'h3a; // ":"
   localparam byte_t CH_NL    = 8'h0a; // Line feed
   localparam byte_t CH_CR    = 8'h0d; // Carriage return

endpackage

// File: uart_rx.sv
module uart_rx
   import uart_pkg::*;
#(
   parameter int P_CLKS_PER_BIT = 16
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     i_rx,
   output rx_word_t o_rx
);

   localparam int               LP_CW   = $clog2(P_CLKS_PER_BIT);
   localparam logic [LP_CW-1:0] LP_LAST = LP_CW'(P_CLKS_PER_BIT - 1);
   localparam logic [LP_CW-1:0] LP_HALF = LP_CW'(P_CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } rx_state_t;

   rx_state_t        state;
   logic [1:0]       rx_sync;  // Two-stage synchronizer
   logic             rx_last;  // Previous synchronized level
   logic             rx_line;
   logic             rx_fall;
   logic [LP_CW-1:0] clk_cnt;
   logic [2:0]       bit_idx;
   byte_t            shift;

   assign rx_line = rx_sync[1];
   assign rx_fall = rx_last && !rx_line;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_sync <= 2'b11;
         rx_last <= 1'b1;
      end
      else
      begin
         rx_sync <= {rx_sync[0], i_rx};
         rx_last <= rx_line;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= st_idle;
         clk_cnt    <= '0;
         bit_idx    <= '0;
         o_rx.valid <= 1'b0;
      end
      else
      begin
         o_rx.valid <= 1'b0; // Single-cycle strobe
         case (state)
            st_idle:
               if (rx_fall)
               begin
                  state   <= st_start;
                  clk_cnt <= '0;
               end
            st_start:
               if (clk_cnt == LP_HALF)
               begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  // Glitch if the line went back high
                  state   <= rx_line ? st_idle : st_data;
               end
               else
               begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            st_data:
               if (clk_cnt == LP_LAST)
               begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7)
                     state <= st_stop;
               end
               else
               begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            st_stop:
               if (clk_cnt == LP_LAST)
               begin
                  clk_cnt    <= '0;
                  state      <= st_idle;
                  o_rx.valid <= rx_line; // Framing error drops the byte
               end
               else
               begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   // Data path, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (state == st_data && clk_cnt == LP_LAST)
         shift <= {rx_line, shift[7:1]};
      if (state == st_stop && clk_cnt == LP_LAST && rx_line)
         o_rx.data <= shift; // Held until next good byte
   end

endmodule

// File: uart_top.sv
module uart_top
   import uart_pkg::*;
#(
   parameter int P_DP_WIDTH     = 16,
   parameter int P_CLKS_PER_BIT = 16,
   parameter int P_FIFO_DEPTH   = 8
)
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  i_rx,
   input  reg_sel_t              i_tx_reg,
   input  logic [P_DP_WIDTH-1:0] i_tx_data,
   input  logic                  i_tx_stb,
   output logic                  o_tx,
   output logic                  o_tx_busy,
   output byte_t                 o_rx_data,
   output logic                  o_rx_valid
);

   localparam int LP_NIBS = P_DP_WIDTH / 4;
   localparam int LP_NCW  = (LP_NIBS > 1) ? $clog2(LP_NIBS) : 1;
   localparam logic [LP_NCW-1:0] LP_NIB_LAST = LP_NCW'(LP_NIBS - 1);

   typedef logic [3:0] nib_t;

   typedef enum logic [2:0] {
      st_idle,
      st_r,
      st_n,
      st_c,
      st_nib,
      st_nl,
      st_cr
   } fmt_state_t;

   fmt_state_t              state;
   logic [LP_NCW-1:0]       nib_cnt;
   logic [P_DP_WIDTH-1:0]   tx_val;   // Value, shifted a nibble per hex char
   reg_sel_t                tx_reg;
   logic                    accept;
   logic                    advance;

   byte_t                   fifo_din;
   byte_t                   fifo_dout;
   logic                    fifo_wr;
   logic                    fifo_rd;
   logic                    fifo_full;
   logic                    fifo_empty;

   logic                    tx_start; // Registered pop
   byte_t                   tx_byte;
   logic                    tx_active;
   rx_word_t                rx_word;

   function automatic byte_t nib_to_ascii(input nib_t nib);
      byte_t c;
      if (nib < 4'd10)
         c = 8'h30 + byte_t'(nib);          // "0" to "9"
      else
         c = 8'h41 + byte_t'(nib - 4'd10);  // "A" to "F"
      return c;
   endfunction

   assign accept    = (state == st_idle) && i_tx_stb;
   assign advance   = !fifo_full;           // Full FIFO stalls the formatter
   assign o_tx_busy = (state != st_idle);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= st_idle;
         nib_cnt <= '0;
      end
      else
      begin
         case (state)
            st_idle:
               if (accept)
                  state <= st_r;
            st_r:
               if (advance)
                  state <= st_n;
            st_n:
               if (advance)
                  state <= st_c;
            st_c:
               if (advance)
               begin
                  state   <= st_nib;
                  nib_cnt <= '0;
               end
            st_nib:
               if (advance)
               begin
                  if (nib_cnt == LP_NIB_LAST)
                     state <= st_nl;
                  else
                     nib_cnt <= nib_cnt + 1'b1;
               end
            st_nl:
               if (advance)
                  state <= st_cr;
            st_cr:
               if (advance)
                  state <= st_idle; // Last char written here
            default:
               state <= st_idle;
         endcase
      end
   end

   // Captured request
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         tx_val <= i_tx_data;
         tx_reg <= i_tx_reg;
      end
      else if (state == st_nib && advance)
      begin
         tx_val <= tx_val << 4;
      end
   end

   always_comb
   begin
      case (state)
         st_r:    fifo_din = CH_R;
         st_n:    fifo_din = 8'h30 + byte_t'(tx_reg); // Register digit
         st_c:    fifo_din = CH_COLON;
         st_nl:   fifo_din = CH_NL;
         st_cr:   fifo_din = CH_CR;
         default: fifo_din = nib_to_ascii(tx_val[P_DP_WIDTH-1 -: 4]);
      endcase
   end

   assign fifo_wr = o_tx_busy && advance;

   // One pop per character, spaced so the active flag can rise in between
   assign fifo_rd = !fifo_empty && !tx_active && !tx_start;

   always_ff @(posedge clk)
   begin
      if (rst)
         tx_start <= 1'b0;
      else
         tx_start <= fifo_rd;
   end

   // Head moves on the pop edge, so keep the popped char
   always_ff @(posedge clk)
   begin
      if (fifo_rd)
         tx_byte <= fifo_dout;
   end

   uart_fifo #(
      .P_FIFO_DEPTH (P_FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .i_wr    (fifo_wr),
      .i_din   (fifo_din),
      .i_rd    (fifo_rd),
      .o_dout  (fifo_dout),
      .o_full  (fifo_full),
      .o_empty (fifo_empty)
   );

   uart_tx #(
      .P_CLKS_PER_BIT (P_CLKS_PER_BIT)
   ) u_tx (
      .clk      (clk),
      .rst      (rst),
      .i_start  (tx_start),
      .i_byte   (tx_byte),
      .o_active (tx_active),
      .o_tx     (o_tx)
   );

   uart_rx #(
      .P_CLKS_PER_BIT (P_CLKS_PER_BIT)
   ) u_rx (
      .clk  (clk),
      .rst  (rst),
      .i_rx (i_rx),
      .o_rx (rx_word)
   );

   assign o_rx_data  = rx_word.data;
   assign o_rx_valid = rx_word.valid;

endmodule

// File: uart_tx.sv
module uart_tx
   import uart_pkg::*;
#(
   parameter int P_CLKS_PER_BIT = 16
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  i_start,
   input  byte_t i_byte,
   output logic  o_active,
   output logic  o_tx
);

   localparam int               LP_CW   = $clog2(P_CLKS_PER_BIT);
   localparam logic [LP_CW-1:0] LP_LAST = LP_CW'(P_CLKS_PER_BIT - 1);

   logic [9:0]       frame;   // Stop, data LSB first, start
   logic [LP_CW-1:0] clk_cnt;
   logic [3:0]       bit_idx;
   logic             bit_end;

   assign bit_end = (clk_cnt == LP_LAST);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         frame    <= '1; // Line idles high
         clk_cnt  <= '0;
         bit_idx  <= '0;
         o_active <= 1'b0;
      end
      else if (!o_active)
      begin
         // A start pulse while active is not possible from the read control
         if (i_start)
         begin
            frame    <= {1'b1, i_byte, 1'b0};
            clk_cnt  <= '0;
            bit_idx  <= '0;
            o_active <= 1'b1;
         end
      end
      else if (bit_end)
      begin
         clk_cnt <= '0;
         frame   <= {1'b1, frame[9:1]}; // Refill with idle level
         if (bit_idx == 4'd9)
            o_active <= 1'b0; // End of stop bit
         else
            bit_idx <= bit_idx + 4'd1;
      end
      else
      begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // Straight from a flop so the line never glitches
   assign o_tx = frame[0];

endmodule
